//--- Makefile
VERILATOR ?= verilator
TOP := CpuTb
FILELIST := filelist.f
BUILD_DIR := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS := --binary --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- filelist.f
+incdir+hdl
hdl/CpuPkg.sv
hdl/Decoder.sv
hdl/Alu.sv
hdl/RegisterFile.sv
hdl/ProgramCounter.sv
hdl/Controller.sv
hdl/Cpu.sv
sim/Cpu_properties.sv
sim/CpuTb.sv

//--- hdl/Alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "Cpu_config.svh"

module Alu (
	input logic [`DataWidth-1:0] a,
	input logic [`DataWidth-1:0] b,
	input CpuPkg::AluOp aluOp,
	output logic [`DataWidth-1:0] aluO
);

	localparam int ShamtWidth = $clog2(`DataWidth);

	logic [ShamtWidth-1:0] shamt;
	logic lessThan;

	assign shamt = b[ShamtWidth-1:0];
	assign lessThan = $signed(a) < $signed(b);

	always_comb
	begin
		case (aluOp)
			CpuPkg::Add: aluO = a + b;
			CpuPkg::Sub: aluO = a - b;
			CpuPkg::And: aluO = a & b;
			CpuPkg::Or: aluO = a | b;
			CpuPkg::Xor: aluO = a ^ b;
			CpuPkg::Slt: aluO = `DataWidth'(lessThan);
			CpuPkg::Sll: aluO = a << shamt;
			CpuPkg::Srl: aluO = a >> shamt; // logical only
			CpuPkg::PassB: aluO = b; // lui
			CpuPkg::Eq: aluO = `DataWidth'(a == b);
			CpuPkg::Ne: aluO = `DataWidth'(a != b);
			CpuPkg::Lt: aluO = `DataWidth'(lessThan);
			CpuPkg::Ge: aluO = `DataWidth'(!lessThan);
			default: aluO = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/Controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "Cpu_config.svh"

module Controller (
	input logic reset,
	input CpuPkg::InstrClass state,
	input logic [`Func3Width-1:0] func3,
	input logic [`DataWidth-1:0] imm,
	input logic [`DataWidth-1:0] regReadData1, // store source, rs2 at the top
	input logic [`DataWidth-1:0] aluO,
	input logic [`DataWidth-1:0] pcReadData,
	output logic regWriteEnable,
	output logic [`DataWidth-1:0] regWriteData,
	output logic [`AddrWidth-1:0] memAddr,
	input logic [`DataWidth-1:0] memReadData,
	output logic memWriteEnable,
	output logic [`DataWidth-1:0] memWriteData,
	output CpuPkg::PcOp pcOp,
	output logic [`DataWidth-1:0] pcWriteData
);

	logic [`DataWidth-1:0] loadData;
	logic [`DataWidth-1:0] storeData;

	always_comb
	begin
		case (func3)
			3'd0: loadData = {{(`DataWidth-8){memReadData[7]}}, memReadData[7:0]}; // lb
			3'd1: loadData = {{(`DataWidth-16){memReadData[15]}}, memReadData[15:0]}; // lh
			3'd4: loadData = {{(`DataWidth-8){1'b0}}, memReadData[7:0]}; // lbu
			3'd5: loadData = {{(`DataWidth-16){1'b0}}, memReadData[15:0]}; // lhu
			default: loadData = memReadData; // lw
		endcase
		// whole word always written
		case (func3)
			3'd0: storeData = {{(`DataWidth-8){regReadData1[7]}}, regReadData1[7:0]};
			3'd1: storeData = {{(`DataWidth-16){regReadData1[15]}}, regReadData1[15:0]};
			default: storeData = regReadData1;
		endcase
	end

	always_comb
	begin
		regWriteEnable = 1'b0;
		regWriteData = '0;
		memAddr = `AddrWidth'(aluO);
		memWriteEnable = 1'b0;
		memWriteData = '0;
		pcOp = CpuPkg::PCAdd4;
		pcWriteData = imm;
		case (state)
			CpuPkg::RegWrite:
			begin
				regWriteData = aluO;
				regWriteEnable = 1'b1;
			end
			CpuPkg::MemReadRegWrite:
			begin
				regWriteData = loadData;
				regWriteEnable = 1'b1;
			end
			CpuPkg::MemWrite:
			begin
				memWriteData = storeData;
				memWriteEnable = 1'b1;
			end
			CpuPkg::PCSelectWrite: pcOp = aluO[0] ? CpuPkg::PCAddImm : CpuPkg::PCAdd4;
			CpuPkg::PCWrite:
			begin
				pcOp = CpuPkg::PCSetImm;
				pcWriteData = aluO; // jump target
				regWriteData = pcReadData;
				regWriteEnable = 1'b1;
			end
			default: ; // Idle just steps on
		endcase
		if (reset)
		begin
			pcOp = CpuPkg::PCClear;
			regWriteEnable = 1'b0;
			memWriteEnable = 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/Cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "Cpu_config.svh"

module Cpu (
	input logic clk,
	input logic reset,
	output logic [`AddrWidth-1:0] instrAddr,
	input logic [`DataWidth-1:0] instr,
	output logic [`AddrWidth-1:0] memAddr,
	input logic [`DataWidth-1:0] memReadData,
	output logic memWriteEnable,
	output logic [`DataWidth-1:0] memWriteData
);

	CpuPkg::InstrClass instrClass;
	CpuPkg::AluOp aluOp;
	CpuPkg::PcOp pcOp;
	logic [`RegAddrWidth-1:0] rs1;
	logic [`RegAddrWidth-1:0] rs2;
	logic [`RegAddrWidth-1:0] rd;
	logic [`Func3Width-1:0] func3;
	logic aluSrcPc;
	logic aluSrcImm;
	logic [`DataWidth-1:0] imm;
	logic [`DataWidth-1:0] regReadData1;
	logic [`DataWidth-1:0] regReadData2;
	logic [`DataWidth-1:0] aluA;
	logic [`DataWidth-1:0] aluB;
	logic [`DataWidth-1:0] aluO;
	logic regWriteEnable;
	logic [`DataWidth-1:0] regWriteData;
	logic [`DataWidth-1:0] pcWriteData;
	logic [`DataWidth-1:0] pcReadData;
	logic [`AddrWidth-1:0] pc;

	assign instrAddr = pc;

	// operand selects
	assign aluA = aluSrcPc ? `DataWidth'(pc) : regReadData1; // jal
	assign aluB = aluSrcImm ? imm : regReadData2;

	Decoder decoder (
		.*
	);

	RegisterFile registerFile (
		.*
	);

	Alu alu (
		.a(aluA),
		.b(aluB),
		.*
	);

	Controller controller (
		.state(instrClass),
		.regReadData1(regReadData2), // store data comes from rs2
		.*
	);

	ProgramCounter programCounter (
		.*
	);

endmodule

`default_nettype wire

//--- hdl/CpuPkg.sv
`default_nettype none

package CpuPkg;

	// instruction kind, used by the controller as its state
	typedef enum logic [2:0]
	{
		Idle,
		RegWrite,
		MemReadRegWrite,
		MemWrite,
		PCSelectWrite,
		PCWrite
	} InstrClass;

	typedef enum logic [1:0]
	{
		PCClear,
		PCAdd4,
		PCAddImm, // pc + pcWriteData
		PCSetImm // pcWriteData, bit 0 cleared
	} PcOp;

	typedef enum logic [3:0]
	{
		Add, Sub, And, Or, Xor, Slt, Sll, Srl,
		PassB,
		Eq, Ne, Lt, Ge // compares give 1 or 0
	} AluOp;

endpackage

`default_nettype wire

//--- hdl/Cpu_config.svh
`ifndef CpuConfigSvh
`define CpuConfigSvh

`define DataWidth 32
`define AddrWidth 32
`define RegAddrWidth 5
`define Func3Width 3
`define OpcodeWidth 7

// RV32I base opcodes in instr[6:0]
`define OpcLui 7'b0110111
`define OpcOp 7'b0110011
`define OpcOpImm 7'b0010011
`define OpcLoad 7'b0000011
`define OpcStore 7'b0100011
`define OpcBranch 7'b1100011
`define OpcJal 7'b1101111
`define OpcJalr 7'b1100111

`endif

//--- hdl/Decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "Cpu_config.svh"

module Decoder (
	input logic [`DataWidth-1:0] instr,
	output CpuPkg::InstrClass instrClass,
	output logic [`RegAddrWidth-1:0] rs1,
	output logic [`RegAddrWidth-1:0] rs2,
	output logic [`RegAddrWidth-1:0] rd,
	output logic [`Func3Width-1:0] func3,
	output CpuPkg::AluOp aluOp,
	output logic aluSrcPc,
	output logic aluSrcImm,
	output logic [`DataWidth-1:0] imm
);

	logic [`OpcodeWidth-1:0] opcode;
	logic [`DataWidth-1:0] immI;
	logic [`DataWidth-1:0] immS;
	logic [`DataWidth-1:0] immB;
	logic [`DataWidth-1:0] immU;
	logic [`DataWidth-1:0] immJ;
	CpuPkg::AluOp aluOpFunc3;
	CpuPkg::AluOp branchOp;

	assign opcode = instr[`OpcodeWidth-1:0];
	assign rd = instr[11:7];
	assign func3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// shared by OP and OP-IMM
	always_comb
	begin
		case (func3)
			3'd1: aluOpFunc3 = CpuPkg::Sll;
			3'd2: aluOpFunc3 = CpuPkg::Slt;
			3'd4: aluOpFunc3 = CpuPkg::Xor;
			3'd5: aluOpFunc3 = CpuPkg::Srl;
			3'd6: aluOpFunc3 = CpuPkg::Or;
			3'd7: aluOpFunc3 = CpuPkg::And;
			default: aluOpFunc3 = CpuPkg::Add;
		endcase
		case (func3)
			3'd1: branchOp = CpuPkg::Ne;
			3'd4: branchOp = CpuPkg::Lt;
			3'd5: branchOp = CpuPkg::Ge;
			default: branchOp = CpuPkg::Eq;
		endcase
	end

	always_comb
	begin
		instrClass = CpuPkg::Idle; // unknown opcode
		aluOp = CpuPkg::Add;
		aluSrcPc = 1'b0;
		aluSrcImm = 1'b1;
		imm = immI;
		case (opcode)
			`OpcOp:
			begin
				instrClass = CpuPkg::RegWrite;
				aluSrcImm = 1'b0;
				aluOp = (func3 == 3'd0 && instr[30]) ? CpuPkg::Sub : aluOpFunc3;
			end
			`OpcOpImm:
			begin
				instrClass = CpuPkg::RegWrite;
				aluOp = aluOpFunc3;
			end
			`OpcLui:
			begin
				instrClass = CpuPkg::RegWrite;
				aluOp = CpuPkg::PassB;
				imm = immU;
			end
			`OpcLoad: instrClass = CpuPkg::MemReadRegWrite;
			`OpcStore:
			begin
				instrClass = CpuPkg::MemWrite;
				imm = immS;
			end
			`OpcBranch:
			begin
				instrClass = CpuPkg::PCSelectWrite;
				aluSrcImm = 1'b0; // compare rs1 with rs2
				aluOp = branchOp;
				imm = immB;
			end
			`OpcJal:
			begin
				instrClass = CpuPkg::PCWrite;
				aluSrcPc = 1'b1;
				imm = immJ;
			end
			`OpcJalr: instrClass = CpuPkg::PCWrite;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/ProgramCounter.sv
`timescale 1ns/1ps
`default_nettype none
`include "Cpu_config.svh"

module ProgramCounter (
	input logic clk,
	input CpuPkg::PcOp pcOp,
	input logic [`DataWidth-1:0] pcWriteData,
	output logic [`AddrWidth-1:0] pc,
	output logic [`DataWidth-1:0] pcReadData
);

	logic [`AddrWidth-1:0] target;

	assign target = `AddrWidth'(pcWriteData);
	assign pcReadData = `DataWidth'(pc + `AddrWidth'(4)); // link value for jal/jalr

	// cleared only through PCClear while the core is in reset
	always_ff @(posedge clk)
	begin
		case (pcOp)
			CpuPkg::PCClear: pc <= '0;
			CpuPkg::PCAdd4: pc <= pc + `AddrWidth'(4);
			CpuPkg::PCAddImm: pc <= pc + target; // taken branch
			CpuPkg::PCSetImm: pc <= {target[`AddrWidth-1:1], 1'b0};
			default: pc <= pc + `AddrWidth'(4);
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/RegisterFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "Cpu_config.svh"

module RegisterFile (
	input logic clk,
	input logic reset,
	input logic [`RegAddrWidth-1:0] rs1,
	input logic [`RegAddrWidth-1:0] rs2,
	output logic [`DataWidth-1:0] regReadData1,
	output logic [`DataWidth-1:0] regReadData2,
	input logic [`RegAddrWidth-1:0] rd,
	input logic regWriteEnable,
	input logic [`DataWidth-1:0] regWriteData
);

	localparam int RegCount = 1 << `RegAddrWidth;

	logic [`DataWidth-1:0] regs [1:RegCount-1]; // no storage for x0

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 1; i < RegCount; i++)
				regs[i] <= '0;
		end
		else if (regWriteEnable && rd != '0)
			regs[rd] <= regWriteData;
	end

	assign regReadData1 = (rs1 == '0) ? '0 : regs[rs1];
	assign regReadData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- sim/CpuTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "Cpu_config.svh"

module CpuTb;

	localparam int ClkPeriod = 4;
	localparam int ResetCycles = 8;
	localparam int ImemWords = 256;
	localparam int DmemWords = 1024;
	localparam int LoopCount = 5; // bne loop iterations
	localparam logic [`AddrWidth-1:0] LastStoreAddr = 32'hffc;

	logic clk = 1'b0;
	logic reset;
	logic [`AddrWidth-1:0] instrAddr;
	logic [`DataWidth-1:0] instr;
	logic [`AddrWidth-1:0] memAddr;
	logic [`DataWidth-1:0] memReadData;
	logic memWriteEnable;
	logic [`DataWidth-1:0] memWriteData;

	logic [`DataWidth-1:0] imem [0:ImemWords-1];
	logic [`DataWidth-1:0] dmem [0:DmemWords-1];
	logic [`DataWidth-1:0] refMem [0:DmemWords-1]; // model copy of dmem
	logic [`DataWidth-1:0] refRegs [0:31];
	logic [`AddrWidth-1:0] refPc;
	logic [11:0] storeOff;
	int progLen;

	Cpu uut (.*);

	always #(ClkPeriod / 2) clk = ~clk;

	assign instr = imem[instrAddr[9:2]];
	assign memReadData = dmem[memAddr[11:2]]; // low two bits ignored

	always @(posedge clk)
	begin
		if (memWriteEnable)
			dmem[memAddr[11:2]] = memWriteData;
	end

	function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, `OpcOp};
	endfunction

	function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], `OpcStore};
	endfunction

	function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OpcBranch};
	endfunction

	function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, `OpcLui};
	endfunction

	function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OpcJal};
	endfunction

	task automatic put(input logic [31:0] word);
		imem[progLen[7:0]] = word;
		progLen++;
	endtask

	// next result slot off x30
	task automatic storeResult(input logic [4:0] src, input logic [2:0] f3);
		put(sType(storeOff, src, 5'd30, f3));
		storeOff = storeOff + 12'd4;
	endtask

	// branch that skips one increment of x10
	task automatic branchPair(input logic [4:0] rs2, input logic [4:0] rs1,
		input logic [2:0] f3);
		put(bType(13'd8, rs2, rs1, f3));
		put(iType(12'd1, 5'd10, 3'd0, 5'd10, `OpcOpImm));
	endtask

	task automatic loadProgram();
		for (int i = 0; i < ImemWords; i++)
			imem[i[7:0]] = '0; // opcode 0 runs as idle
		progLen = 0;
		storeOff = 12'h000;
		put(iType(12'h400, 5'd0, 3'd0, 5'd30, `OpcOpImm)); // result area
		put(iType(12'd1234, 5'd0, 3'd0, 5'd1, `OpcOpImm));
		put(iType(-12'd77, 5'd0, 3'd0, 5'd2, `OpcOpImm));
		put(uType(20'habcde, 5'd3));
		put(iType(12'h123, 5'd3, 3'd0, 5'd3, `OpcOpImm));
		storeResult(5'd3, 3'd2);
		for (int f = 0; f < 8; f++)
		begin
			if (f != 3)
			begin
				put(rType(7'h00, 5'd2, 5'd3, f[2:0], 5'd4));
				storeResult(5'd4, 3'd2);
				put(iType((f == 1 || f == 5) ? 12'd9 : -12'd300, 5'd3, f[2:0], 5'd4,
					`OpcOpImm));
				storeResult(5'd4, 3'd2);
			end
		end
		put(rType(7'h20, 5'd2, 5'd3, 3'd0, 5'd4)); // sub
		storeResult(5'd4, 3'd2);
		put(rType(7'h00, 5'd3, 5'd1, 3'd2, 5'd4)); // slt false
		storeResult(5'd4, 3'd2);
		put(iType(12'd5, 5'd1, 3'd0, 5'd0, `OpcOpImm)); // writes to x0
		put(rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd0));
		storeResult(5'd0, 3'd2);
		put(iType(12'h100, 5'd0, 3'd0, 5'd6, `OpcOpImm)); // random words here
		for (int f = 0; f < 6; f++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				if (f != 3)
				begin
					put(iType(12'(4 * k), 5'd6, f[2:0], 5'd7, `OpcLoad));
					storeResult(5'd7, 3'd2);
				end
			end
		end
		for (int f = 0; f < 3; f++)
		begin
			storeResult(5'd3, f[2:0]); // sb, sh, sw
			storeResult(5'd2, f[2:0]);
			storeResult(5'd1, f[2:0]);
		end
		put(iType(12'(LoopCount), 5'd0, 3'd0, 5'd9, `OpcOpImm));
		put(iType(12'd1, 5'd8, 3'd0, 5'd8, `OpcOpImm)); // loop body
		put(bType(-13'd4, 5'd9, 5'd8, 3'd1));
		storeResult(5'd8, 3'd2);
		branchPair(5'd9, 5'd8, 3'd0); // beq taken
		branchPair(5'd0, 5'd8, 3'd0);
		branchPair(5'd1, 5'd2, 3'd4); // blt taken
		branchPair(5'd2, 5'd1, 3'd4);
		branchPair(5'd2, 5'd1, 3'd5); // bge taken
		branchPair(5'd1, 5'd2, 3'd5);
		storeResult(5'd10, 3'd2);
		put(jType(21'd8, 5'd11));
		put(iType(12'd100, 5'd10, 3'd0, 5'd10, `OpcOpImm)); // skipped
		storeResult(5'd11, 3'd2);
		// odd jalr target, bit 0 must drop
		put(iType(12'(4 * (progLen + 3) + 1), 5'd0, 3'd0, 5'd13, `OpcOpImm));
		put(iType(12'd0, 5'd13, 3'd0, 5'd12, `OpcJalr));
		put(iType(12'd100, 5'd10, 3'd0, 5'd10, `OpcOpImm));
		storeResult(5'd12, 3'd2);
		storeResult(5'd10, 3'd2);
		put(uType(20'h00001, 5'd14));
		put(sType(-12'd4, 5'd1, 5'd14, 3'd2)); // final store, 0xffc
	endtask

	// one instruction on the model state, straight from the ISA rules
	function automatic void refStep(output logic [31:0] nextPc, output logic isStore,
		output logic [31:0] storeAddr, output logic [31:0] storeData);
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] immI;
		logic [31:0] immS;
		logic [31:0] immB;
		logic [31:0] immJ;
		logic [31:0] res;
		logic [31:0] word;
		logic [31:0] addr;
		logic [2:0] f3;
		logic wr;
		logic taken;
		ins = imem[refPc[9:2]];
		f3 = ins[14:12];
		a = refRegs[ins[19:15]];
		b = refRegs[ins[24:20]];
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		nextPc = refPc + 32'd4;
		isStore = 1'b0;
		storeAddr = '0;
		storeData = '0;
		res = '0;
		wr = 1'b0;
		case (ins[6:0])
			`OpcLui:
			begin
				res = {ins[31:12], 12'b0};
				wr = 1'b1;
			end
			`OpcOp, `OpcOpImm:
			begin
				if (ins[6:0] == `OpcOpImm)
					b = immI;
				wr = 1'b1;
				case (f3)
					3'd1: res = a << b[4:0];
					3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					3'd4: res = a ^ b;
					3'd5: res = a >> b[4:0];
					3'd6: res = a | b;
					3'd7: res = a & b;
					default: res = (ins[6:0] == `OpcOp && ins[30]) ? a - b : a + b;
				endcase
			end
			`OpcLoad:
			begin
				addr = a + immI;
				word = refMem[addr[11:2]];
				wr = 1'b1;
				case (f3)
					3'd0: res = {{24{word[7]}}, word[7:0]};
					3'd1: res = {{16{word[15]}}, word[15:0]};
					3'd4: res = {24'b0, word[7:0]};
					3'd5: res = {16'b0, word[15:0]};
					default: res = word;
				endcase
			end
			`OpcStore:
			begin
				isStore = 1'b1;
				storeAddr = a + immS;
				case (f3)
					3'd0: storeData = {{24{b[7]}}, b[7:0]}; // whole word written
					3'd1: storeData = {{16{b[15]}}, b[15:0]};
					default: storeData = b;
				endcase
				refMem[storeAddr[11:2]] = storeData;
			end
			`OpcBranch:
			begin
				case (f3)
					3'd1: taken = a != b;
					3'd4: taken = $signed(a) < $signed(b);
					3'd5: taken = $signed(a) >= $signed(b);
					default: taken = a == b;
				endcase
				if (taken)
					nextPc = refPc + immB;
			end
			`OpcJal:
			begin
				res = refPc + 32'd4;
				wr = 1'b1;
				nextPc = (refPc + immJ) & ~32'd1;
			end
			`OpcJalr:
			begin
				res = refPc + 32'd4;
				wr = 1'b1;
				nextPc = (a + immI) & ~32'd1;
			end
			default: ; // unknown opcode steps on
		endcase
		if (wr && ins[11:7] != 5'd0)
			refRegs[ins[11:7]] = res;
		refPc = nextPc;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch");
		end
	endtask

	initial
	begin : main
		logic [`AddrWidth-1:0] expPc;
		logic isStore;
		logic [`AddrWidth-1:0] storeAddr;
		logic [`DataWidth-1:0] storeData;
		logic done;
		reset = 1'b1;
		void'($urandom(32'hf943_148c));
		for (int i = 0; i < DmemWords; i++)
		begin
			dmem[i[9:0]] = $urandom;
			refMem[i[9:0]] = dmem[i[9:0]];
		end
		for (int r = 0; r < 32; r++)
			refRegs[r[4:0]] = '0;
		refPc = '0;
		expPc = '0;
		done = 1'b0;
		loadProgram();
		repeat (ResetCycles)
		begin
			@(posedge clk);
			#1;
			checkValue("memWriteEnable", 32'd0, 32'(memWriteEnable));
		end
		reset = 1'b0;
		while (!done)
		begin
			@(negedge clk); // mid cycle, outputs settled
			checkValue("instrAddr", expPc, instrAddr);
			refStep(expPc, isStore, storeAddr, storeData);
			checkValue("memWriteEnable", 32'(isStore), 32'(memWriteEnable));
			if (isStore)
			begin
				checkValue("memAddr", storeAddr, memAddr);
				checkValue("memWriteData", storeData, memWriteData);
				done = (storeAddr == LastStoreAddr);
			end
		end
		$display("*** PASSED ***");
		$finish;
	end

	initial
	begin : watchdog
		#(ClkPeriod * (ResetCycles + ImemWords * LoopCount) + 100);
		$display("timeout: the program never reached its final store");
		$display("*** FAILED ***");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

//--- sim/Cpu_properties.sv
`timescale 1ns/1ps
`default_nettype none
`include "Cpu_config.svh"

module CpuProperties (
	input logic clk,
	input logic reset,
	input logic [`AddrWidth-1:0] pc,
	input logic memWriteEnable,
	input logic regWriteEnable
);

	noWriteInReset: assert property (@(posedge clk)
		reset |-> !memWriteEnable && !regWriteEnable)
		else $error("write enable high while reset is asserted");

	pcAligned: assert property (@(posedge clk) disable iff (reset)
		pc[1:0] == 2'b00)
		else $error("pc is not word-aligned");

	// first cycle out of reset starts at address 0
	pcZeroAfterReset: assert property (@(posedge clk)
		$fell(reset) |-> pc == '0)
		else $error("pc is not zero in the cycle after reset");

endmodule

bind Cpu CpuProperties props (
	.clk(clk),
	.reset(reset),
	.pc(pc),
	.memWriteEnable(memWriteEnable),
	.regWriteEnable(regWriteEnable)
);

`default_nettype wire
